//--- include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address and data word widths
`define ADDR_W 32
`define XLEN 64

// cache geometry, two ways per set
`define SETS 64
`define LINE_WORDS 4
`define TAG_W 21

// backing memory depth in words, index is addr[12:3]
`define MEM_WORDS 1024

`endif

//--- verilog/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`TAG_W-1:0] tag_t;
  typedef logic [$clog2(`SETS)-1:0] index_t;
  typedef logic [$clog2(`LINE_WORDS)-1:0] wordSel_t;
  typedef logic [`LINE_WORDS*`XLEN-1:0] line_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    FILL,
    RESPOND
  } cacheState_e;

endpackage

`default_nettype wire

//--- verilog/cache_way_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_way_array
  import cache_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n,
  input  wire    rdEn_i,
  input  index_t rdIndex_i,
  input  wire    wrEn_i,
  input  index_t wrIndex_i,
  input  tag_t   wrTag_i,
  input  line_t  wrLine_i,
  input  wire    useWay_i,
  input  wire    useEn_i,
  output tag_t   tag0_o,
  output tag_t   tag1_o,
  output logic   valid0_o,
  output logic   valid1_o,
  output line_t  line0_o,
  output line_t  line1_o,
  output logic   victim_o
);

  tag_t  tagMem0  [`SETS];
  tag_t  tagMem1  [`SETS];
  line_t lineMem0 [`SETS];
  line_t lineMem1 [`SETS];

  logic [`SETS-1:0] validBits0;
  logic [`SETS-1:0] validBits1;
  // lru bit names the way to replace next
  logic [`SETS-1:0] lruBits;

  // tag and data storage
  always_ff @(posedge clk) begin
    if (wrEn_i && !lruBits[wrIndex_i]) begin
      tagMem0[wrIndex_i]  <= wrTag_i;
      lineMem0[wrIndex_i] <= wrLine_i;
    end
    if (wrEn_i && lruBits[wrIndex_i]) begin
      tagMem1[wrIndex_i]  <= wrTag_i;
      lineMem1[wrIndex_i] <= wrLine_i;
    end
    if (rdEn_i) begin
      tag0_o  <= tagMem0[rdIndex_i];
      tag1_o  <= tagMem1[rdIndex_i];
      line0_o <= lineMem0[rdIndex_i];
      line1_o <= lineMem1[rdIndex_i];
    end
  end

  // valid and lru state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits0 <= '0;
      validBits1 <= '0;
      lruBits    <= '0;
      valid0_o   <= 1'b0;
      valid1_o   <= 1'b0;
      victim_o   <= 1'b0;
    end else begin
      if (wrEn_i && !lruBits[wrIndex_i]) begin
        validBits0[wrIndex_i] <= 1'b1;
      end
      if (wrEn_i && lruBits[wrIndex_i]) begin
        validBits1[wrIndex_i] <= 1'b1;
      end
      // the other way becomes the next victim
      if (useEn_i) begin
        lruBits[wrIndex_i] <= ~useWay_i;
      end
      if (rdEn_i) begin
        valid0_o <= validBits0[rdIndex_i];
        valid1_o <= validBits1[rdIndex_i];
        victim_o <= lruBits[rdIndex_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache
  import cache_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   valid_i,
  input  addr_t addr_i,
  output logic  addr_ok_o,
  output logic  data_ok_o,
  output word_t rd_data_o,
  output logic  hit_o,
  output logic  psel_o,
  output logic  penable_o,
  output addr_t paddr_o,
  output logic  pwrite_o,
  output word_t pwdata_o,
  input  word_t prdata_i,
  input  wire   pready_i
);

  localparam int WORD_LSB = $clog2(`XLEN / 8);
  localparam int LINE_LSB = WORD_LSB + $bits(wordSel_t);
  localparam int TAG_LSB = LINE_LSB + $bits(index_t);
  localparam wordSel_t LAST_WORD = wordSel_t'(`LINE_WORDS - 1);

  cacheState_e state;
  cacheState_e nextState;

  addr_t    reqAddr;
  tag_t     reqTag;
  index_t   reqIndex;
  wordSel_t reqSel;
  wordSel_t wordCnt;
  line_t    lineBuf;
  word_t    rdDataQ;
  logic     hitQ;
  logic     dataOkQ;

  logic  accept;
  tag_t  tag0;
  tag_t  tag1;
  logic  valid0;
  logic  valid1;
  line_t line0;
  line_t line1;
  logic  victim;
  logic  way0Hit;
  logic  way1Hit;
  logic  hit;
  line_t hitLine;
  word_t hitWord;
  logic  useEn;
  logic  useWay;

  assign accept   = valid_i && addr_ok_o;
  assign reqTag   = reqAddr[TAG_LSB +: `TAG_W];
  assign reqIndex = reqAddr[LINE_LSB +: $bits(index_t)];
  assign reqSel   = reqAddr[WORD_LSB +: $bits(wordSel_t)];

  // hit compare on the registered array read
  assign way0Hit = valid0 && (tag0 == reqTag);
  assign way1Hit = valid1 && (tag1 == reqTag);
  assign hit     = way0Hit || way1Hit;
  assign hitLine = way1Hit ? line1 : line0;
  assign hitWord = hitLine[reqSel*`XLEN +: `XLEN];

  // hit marks the hit way, refill marks the victim
  assign useEn  = ((state == LOOKUP) && hit) || ((state == RESPOND) && !hitQ);
  assign useWay = (state == LOOKUP) ? way1Hit : victim;

  cache_way_array u_ways (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdEn_i    (accept),
    .rdIndex_i (addr_i[LINE_LSB +: $bits(index_t)]),
    .wrEn_i    ((state == RESPOND) && !hitQ),
    .wrIndex_i (reqIndex),
    .wrTag_i   (reqTag),
    .wrLine_i  (lineBuf),
    .useWay_i  (useWay),
    .useEn_i   (useEn),
    .tag0_o    (tag0),
    .tag1_o    (tag1),
    .valid0_o  (valid0),
    .valid1_o  (valid1),
    .line0_o   (line0),
    .line1_o   (line1),
    .victim_o  (victim)
  );

  always_comb begin
    nextState = state;
    case (state)
      IDLE:    if (valid_i) nextState = LOOKUP;
      LOOKUP:  nextState = hit ? RESPOND : REFILL;
      REFILL:  nextState = FILL;
      FILL: begin
        if (pready_i) begin
          nextState = (wordCnt == LAST_WORD) ? RESPOND : REFILL;
        end
      end
      RESPOND: nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      wordCnt <= '0;
      hitQ    <= 1'b0;
      dataOkQ <= 1'b0;
    end else begin
      state   <= nextState;
      dataOkQ <= (state == RESPOND);
      if (state == LOOKUP) begin
        wordCnt <= '0;
        hitQ    <= hit;
      end else if ((state == FILL) && pready_i) begin
        wordCnt <= wordCnt + 1'b1;
      end
    end
  end

  // request latch, refill buffer and response word
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
    if ((state == LOOKUP) && hit) begin
      rdDataQ <= hitWord;
    end
    if ((state == FILL) && pready_i) begin
      lineBuf[wordCnt*`XLEN +: `XLEN] <= prdata_i;
      if (wordCnt == reqSel) begin
        rdDataQ <= prdata_i;
      end
    end
  end

  assign addr_ok_o = (state == IDLE);
  assign data_ok_o = dataOkQ;
  assign rd_data_o = rdDataQ;
  assign hit_o     = hitQ;

  // line-aligned word reads, setup in REFILL and access in FILL
  assign psel_o    = (state == REFILL) || (state == FILL);
  assign penable_o = (state == FILL);
  assign paddr_o   = {reqTag, reqIndex, wordCnt, {WORD_LSB{1'b0}}};
  assign pwrite_o  = 1'b0;
  assign pwdata_o  = '0;

endmodule

`default_nettype wire

//--- verilog/apb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module apb_arbiter
  import cache_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   r0_psel_i,
  input  wire   r0_penable_i,
  input  addr_t r0_paddr_i,
  input  wire   r0_pwrite_i,
  input  word_t r0_pwdata_i,
  output word_t r0_prdata_o,
  output logic  r0_pready_o,
  input  wire   r1_psel_i,
  input  wire   r1_penable_i,
  input  addr_t r1_paddr_i,
  input  wire   r1_pwrite_i,
  input  word_t r1_pwdata_i,
  output word_t r1_prdata_o,
  output logic  r1_pready_o,
  input  wire   r2_psel_i,
  input  wire   r2_penable_i,
  input  addr_t r2_paddr_i,
  input  wire   r2_pwrite_i,
  input  word_t r2_pwdata_i,
  output word_t r2_prdata_o,
  output logic  r2_pready_o,
  output logic  m_psel_o,
  output logic  m_penable_o,
  output addr_t m_paddr_o,
  output logic  m_pwrite_o,
  output word_t m_pwdata_o,
  input  word_t m_prdata_i,
  input  wire   m_pready_i
);

  localparam int NREQ = 3;

  logic [NREQ-1:0] reqPsel;
  logic [NREQ-1:0] reqPenable;
  logic [NREQ-1:0] reqPwrite;
  addr_t           reqAddr  [NREQ];
  word_t           reqWdata [NREQ];

  logic       busy;
  logic [1:0] grantIdx;
  logic [1:0] lastWinner;
  logic [1:0] winner;
  logic [1:0] curIdx;
  logic       found;

  assign reqPsel    = {r2_psel_i, r1_psel_i, r0_psel_i};
  assign reqPenable = {r2_penable_i, r1_penable_i, r0_penable_i};
  assign reqPwrite  = {r2_pwrite_i, r1_pwrite_i, r0_pwrite_i};
  assign reqAddr[0]  = r0_paddr_i;
  assign reqAddr[1]  = r1_paddr_i;
  assign reqAddr[2]  = r2_paddr_i;
  assign reqWdata[0] = r0_pwdata_i;
  assign reqWdata[1] = r1_pwdata_i;
  assign reqWdata[2] = r2_pwdata_i;

  // round robin, search starts after the last winner
  always_comb begin
    int idx;
    winner = lastWinner;
    found  = 1'b0;
    for (int k = 1; k <= NREQ; k++) begin
      idx = (int'(lastWinner) + k) % NREQ;
      if (!found && reqPsel[idx]) begin
        winner = 2'(idx);
        found  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      grantIdx   <= '0;
      lastWinner <= 2'(NREQ - 1);
    end else if (!busy && found) begin
      busy     <= 1'b1;
      grantIdx <= winner;
    end else if (busy && m_pready_i) begin
      busy       <= 1'b0;
      lastWinner <= grantIdx;
    end
  end

  // idle link forwards the winner as a setup phase
  assign curIdx      = busy ? grantIdx : winner;
  assign m_psel_o    = reqPsel[curIdx];
  assign m_penable_o = busy && reqPenable[grantIdx];
  assign m_paddr_o   = reqAddr[curIdx];
  assign m_pwrite_o  = reqPwrite[curIdx];
  assign m_pwdata_o  = reqWdata[curIdx];

  assign r0_prdata_o = m_prdata_i;
  assign r1_prdata_o = m_prdata_i;
  assign r2_prdata_o = m_prdata_i;
  assign r0_pready_o = busy && (grantIdx == 2'd0) && m_pready_i;
  assign r1_pready_o = busy && (grantIdx == 2'd1) && m_pready_i;
  assign r2_pready_o = busy && (grantIdx == 2'd2) && m_pready_i;

endmodule

`default_nettype wire

//--- verilog/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module line_memory
  import cache_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   psel_i,
  input  wire   penable_i,
  input  addr_t paddr_i,
  input  wire   pwrite_i,
  input  word_t pwdata_i,
  output word_t prdata_o,
  output logic  pready_o
);

  localparam int IDX_LSB = $clog2(`XLEN / 8);
  localparam int IDX_W = $clog2(`MEM_WORDS);

  word_t mem [`MEM_WORDS];

  logic [IDX_W-1:0] wordIdx;
  logic             access;
  logic             waitDone;
  word_t            rdDataQ;

  // higher address bits alias
  assign wordIdx = paddr_i[IDX_LSB +: IDX_W];
  assign access  = psel_i && penable_i;

  // one wait state in every access phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waitDone <= 1'b0;
    end else begin
      waitDone <= access && !waitDone;
    end
  end

  always_ff @(posedge clk) begin
    if (access && !waitDone) begin
      rdDataQ <= mem[wordIdx];
    end
    if (access && waitDone && pwrite_i) begin
      mem[wordIdx] <= pwdata_i;
    end
  end

  assign pready_o = access && waitDone;
  assign prdata_o = rdDataQ;

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   iValid_i,
  input  addr_t iAddr_i,
  output logic  iAddrOk_o,
  output logic  iDataOk_o,
  output word_t iRdData_o,
  output logic  iHit_o,
  input  wire   dValid_i,
  input  addr_t dAddr_i,
  output logic  dAddrOk_o,
  output logic  dDataOk_o,
  output word_t dRdData_o,
  output logic  dHit_o,
  input  wire   host_psel_i,
  input  wire   host_penable_i,
  input  addr_t host_paddr_i,
  input  wire   host_pwrite_i,
  input  word_t host_pwdata_i,
  output word_t host_prdata_o,
  output logic  host_pready_o
);

  logic  iPsel;
  logic  iPenable;
  logic  iPwrite;
  logic  iPready;
  addr_t iPaddr;
  word_t iPwdata;
  word_t iPrdata;
  logic  dPsel;
  logic  dPenable;
  logic  dPwrite;
  logic  dPready;
  addr_t dPaddr;
  word_t dPwdata;
  word_t dPrdata;
  logic  mPsel;
  logic  mPenable;
  logic  mPwrite;
  logic  mPready;
  addr_t mPaddr;
  word_t mPwdata;
  word_t mPrdata;

  cache u_icache (
    .clk (clk), .rst_n (rst_n),
    .valid_i (iValid_i), .addr_i (iAddr_i), .addr_ok_o (iAddrOk_o),
    .data_ok_o (iDataOk_o), .rd_data_o (iRdData_o), .hit_o (iHit_o),
    .psel_o (iPsel), .penable_o (iPenable), .paddr_o (iPaddr),
    .pwrite_o (iPwrite), .pwdata_o (iPwdata), .prdata_i (iPrdata), .pready_i (iPready)
  );

  cache u_dcache (
    .clk (clk), .rst_n (rst_n),
    .valid_i (dValid_i), .addr_i (dAddr_i), .addr_ok_o (dAddrOk_o),
    .data_ok_o (dDataOk_o), .rd_data_o (dRdData_o), .hit_o (dHit_o),
    .psel_o (dPsel), .penable_o (dPenable), .paddr_o (dPaddr),
    .pwrite_o (dPwrite), .pwdata_o (dPwdata), .prdata_i (dPrdata), .pready_i (dPready)
  );

  // host port takes the last requester slot
  apb_arbiter u_arbiter (
    .clk (clk), .rst_n (rst_n),
    .r0_psel_i (iPsel), .r0_penable_i (iPenable), .r0_paddr_i (iPaddr),
    .r0_pwrite_i (iPwrite), .r0_pwdata_i (iPwdata),
    .r0_prdata_o (iPrdata), .r0_pready_o (iPready),
    .r1_psel_i (dPsel), .r1_penable_i (dPenable), .r1_paddr_i (dPaddr),
    .r1_pwrite_i (dPwrite), .r1_pwdata_i (dPwdata),
    .r1_prdata_o (dPrdata), .r1_pready_o (dPready),
    .r2_psel_i (host_psel_i), .r2_penable_i (host_penable_i), .r2_paddr_i (host_paddr_i),
    .r2_pwrite_i (host_pwrite_i), .r2_pwdata_i (host_pwdata_i),
    .r2_prdata_o (host_prdata_o), .r2_pready_o (host_pready_o),
    .m_psel_o (mPsel), .m_penable_o (mPenable), .m_paddr_o (mPaddr),
    .m_pwrite_o (mPwrite), .m_pwdata_o (mPwdata),
    .m_prdata_i (mPrdata), .m_pready_i (mPready)
  );

  line_memory u_memory (
    .clk (clk), .rst_n (rst_n),
    .psel_i (mPsel), .penable_i (mPenable), .paddr_i (mPaddr),
    .pwrite_i (mPwrite), .pwdata_i (mPwdata),
    .prdata_o (mPrdata), .pready_o (mPready)
  );

endmodule

`default_nettype wire

//--- testbench/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cache_checker
  import cache_pkg::*;
(
  input wire        clk,
  input wire        rst_n,
  input wire        iValid_i,
  input wire        iAddrOk_i,
  input wire        iDataOk_i,
  input wire        iHit_i,
  input wire        dValid_i,
  input wire        dAddrOk_i,
  input wire        dDataOk_i,
  input wire        dHit_i,
  input wire        mPsel_i,
  input wire        mPenable_i,
  input wire addr_t mPaddr_i,
  input wire        mPwrite_i,
  input wire word_t mPwdata_i,
  input wire        mPready_i
);

  int failCount = 0;

  // memory link follows setup then access
  enableNeedsSel: assert property (@(posedge clk) disable iff (!rst_n)
    mPenable_i |-> mPsel_i)
    else begin
      failCount++;
      $error("memory link penable high without psel");
    end

  setupBeforeAccess: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mPenable_i) |-> $past(mPsel_i && !mPenable_i))
    else begin
      failCount++;
      $error("memory link access phase without setup");
    end

  // transfer held until pready
  stableUntilReady: assert property (@(posedge clk) disable iff (!rst_n)
    mPsel_i && !mPready_i |=> mPsel_i && $stable(mPaddr_i) && $stable(mPwrite_i)
      && $stable(mPwdata_i))
    else begin
      failCount++;
      $error("memory link changed before pready");
    end

  iDataOkPulse: assert property (@(posedge clk) disable iff (!rst_n)
    iDataOk_i |=> !iDataOk_i)
    else begin
      failCount++;
      $error("instruction data_ok longer than one cycle");
    end

  dDataOkPulse: assert property (@(posedge clk) disable iff (!rst_n)
    dDataOk_i |=> !dDataOk_i)
    else begin
      failCount++;
      $error("data cache data_ok longer than one cycle");
    end

  // hit response two cycles after the accepting edge
  iHitLatency: assert property (@(posedge clk) disable iff (!rst_n)
    iDataOk_i && iHit_i |-> $past(iValid_i && iAddrOk_i, 3))
    else begin
      failCount++;
      $error("instruction hit response off its slot");
    end

  dHitLatency: assert property (@(posedge clk) disable iff (!rst_n)
    dDataOk_i && dHit_i |-> $past(dValid_i && dAddrOk_i, 3))
    else begin
      failCount++;
      $error("data cache hit response off its slot");
    end

endmodule

bind cache_top cache_checker u_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .iValid_i   (iValid_i),
  .iAddrOk_i  (iAddrOk_o),
  .iDataOk_i  (iDataOk_o),
  .iHit_i     (iHit_o),
  .dValid_i   (dValid_i),
  .dAddrOk_i  (dAddrOk_o),
  .dDataOk_i  (dDataOk_o),
  .dHit_i     (dHit_o),
  .mPsel_i    (mPsel),
  .mPenable_i (mPenable),
  .mPaddr_i   (mPaddr),
  .mPwrite_i  (mPwrite),
  .mPwdata_i  (mPwdata),
  .mPready_i  (mPready)
);

`default_nettype wire

//--- testbench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam int HIT_LATENCY = 2;
  localparam string GOLDEN_PATH = "testbench/cache_golden.txt";

  logic  clk;
  logic  rst_n;
  logic  iValid;
  addr_t iAddr;
  logic  iAddrOk;
  logic  iDataOk;
  word_t iRdData;
  logic  iHit;
  logic  dValid;
  addr_t dAddr;
  logic  dAddrOk;
  logic  dDataOk;
  word_t dRdData;
  logic  dHit;
  logic  hostPsel;
  logic  hostPenable;
  addr_t hostPaddr;
  logic  hostPwrite;
  word_t hostPwdata;
  word_t hostPrdata;
  logic  hostPready;

  int   errors;
  int   checks;
  int   timeouts;
  logic timedOut;

  // queued commands, slot 0 icache, 1 dcache, 2 host
  logic  pendValid [3];
  byte   pendCmd [3];
  addr_t pendAddr [3];
  word_t pendData [3];
  logic  pendHit [3];
  string pendName [3];

  cache_top DUT (
    .clk (clk), .rst_n (rst_n),
    .iValid_i (iValid), .iAddr_i (iAddr), .iAddrOk_o (iAddrOk),
    .iDataOk_o (iDataOk), .iRdData_o (iRdData), .iHit_o (iHit),
    .dValid_i (dValid), .dAddr_i (dAddr), .dAddrOk_o (dAddrOk),
    .dDataOk_o (dDataOk), .dRdData_o (dRdData), .dHit_o (dHit),
    .host_psel_i (hostPsel), .host_penable_i (hostPenable), .host_paddr_i (hostPaddr),
    .host_pwrite_i (hostPwrite), .host_pwdata_i (hostPwdata),
    .host_prdata_o (hostPrdata), .host_pready_o (hostPready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // memory contents before any test write
  function automatic word_t fillPattern(input addr_t addr);
    return {addr, ~addr};
  endfunction

  task automatic reportTimeout(input string what);
    $display("timeout: %s got no response within %0d cycles", what, TIMEOUT);
    errors++;
    timeouts++;
    timedOut = 1'b1;
  endtask

  task automatic checkWord(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkHit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      $display("ERR %s hit: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkLatency(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      $display("ERR %s latency: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic hostAccess(input logic write, input addr_t addr, input word_t wdata,
                            output word_t rdata);
    int waitCnt;
    rdata = '0;
    @(posedge clk);
    hostPsel    <= 1'b1;
    hostPenable <= 1'b0;
    hostPaddr   <= addr;
    hostPwrite  <= write;
    hostPwdata  <= wdata;
    @(posedge clk);
    hostPenable <= 1'b1;
    waitCnt = 0;
    @(negedge clk);
    while (!hostPready && waitCnt < TIMEOUT) begin
      @(negedge clk);
      waitCnt++;
    end
    if (hostPready) begin
      rdata = hostPrdata;
    end else begin
      reportTimeout($sformatf("host transfer at %h", addr));
    end
    @(posedge clk);
    hostPsel    <= 1'b0;
    hostPenable <= 1'b0;
  endtask

  task automatic cacheRead(input logic useData, input addr_t addr, output word_t rdata,
                           output logic hit, output int latency);
    int   waitCnt;
    logic ready;
    rdata   = '0;
    hit     = 1'b0;
    latency = 0;
    @(posedge clk);
    if (useData) begin
      dValid <= 1'b1;
      dAddr  <= addr;
    end else begin
      iValid <= 1'b1;
      iAddr  <= addr;
    end
    waitCnt = 0;
    @(negedge clk);
    ready = useData ? dAddrOk : iAddrOk;
    while (!ready && waitCnt < TIMEOUT) begin
      @(negedge clk);
      waitCnt++;
      ready = useData ? dAddrOk : iAddrOk;
    end
    // accepting edge
    @(posedge clk);
    if (useData) begin
      dValid <= 1'b0;
    end else begin
      iValid <= 1'b0;
    end
    if (!ready) begin
      reportTimeout($sformatf("cache request at %h", addr));
      return;
    end
    @(negedge clk);
    ready = useData ? dDataOk : iDataOk;
    while (!ready && latency < TIMEOUT) begin
      @(posedge clk);
      latency++;
      @(negedge clk);
      ready = useData ? dDataOk : iDataOk;
    end
    if (ready) begin
      rdata = useData ? dRdData : iRdData;
      hit   = useData ? dHit : iHit;
    end else begin
      reportTimeout($sformatf("cache response for %h", addr));
    end
  endtask

  task automatic runCommand(input byte cmd, input addr_t addr, input word_t data,
                            input logic expHit, input string name);
    word_t rdata;
    logic  hit;
    int    latency;
    case (cmd)
      "W", "w": hostAccess(1'b1, addr, data, rdata);
      "R", "r": begin
        hostAccess(1'b0, addr, '0, rdata);
        if (!timedOut) checkWord(name, data, rdata);
      end
      "I", "i", "D", "d": begin
        cacheRead(cmd == "D" || cmd == "d", addr, rdata, hit, latency);
        if (!timedOut) begin
          checkWord(name, data, rdata);
          checkHit(name, expHit, hit);
          if (expHit) checkLatency(name, HIT_LATENCY, latency);
        end
      end
      default: begin
        $display("unknown command in %s", name);
        errors++;
      end
    endcase
  endtask

  task automatic fillMemory();
    word_t unused;
    addr_t addr;
    for (int k = 0; k < `MEM_WORDS && !timedOut; k++) begin
      addr = addr_t'(k * (`XLEN / 8));
      hostAccess(1'b1, addr, fillPattern(addr), unused);
    end
  endtask

  task automatic runQueued();
    fork
      begin
        if (pendValid[0]) runCommand(pendCmd[0], pendAddr[0], pendData[0],
                                     pendHit[0], pendName[0]);
      end
      begin
        if (pendValid[1]) runCommand(pendCmd[1], pendAddr[1], pendData[1],
                                     pendHit[1], pendName[1]);
      end
      begin
        if (pendValid[2]) runCommand(pendCmd[2], pendAddr[2], pendData[2],
                                     pendHit[2], pendName[2]);
      end
    join
    for (int s = 0; s < 3; s++) begin
      pendValid[s] = 1'b0;
    end
  endtask

  task automatic runGolden();
    int         fd;
    int         lineNo;
    int         count;
    int         slot;
    string      lineStr;
    string      tok;
    string      name;
    byte        cmd;
    addr_t      addr;
    word_t      data;
    logic [3:0] hitTok;
    fd = $fopen(GOLDEN_PATH, "r");
    if (fd == 0) begin
      $display("could not open %s", GOLDEN_PATH);
      errors++;
      return;
    end
    lineNo = 0;
    while (!$feof(fd) && !timedOut) begin
      lineStr = "";
      void'($fgets(lineStr, fd));
      lineNo++;
      count = $sscanf(lineStr, "%s %h %h %h", tok, addr, data, hitTok);
      if (count <= 0 || tok[0] == "#") continue;
      if (count != 4) begin
        $display("line %0d of %s is malformed", lineNo, GOLDEN_PATH);
        errors++;
        continue;
      end
      cmd  = tok[0];
      name = $sformatf("line %0d %s %h", lineNo, tok, addr);
      case (cmd)
        "F": fillMemory();
        "i", "d", "r", "w": begin
          slot = (cmd == "i") ? 0 : ((cmd == "d") ? 1 : 2);
          pendValid[slot] = 1'b1;
          pendCmd[slot]   = cmd;
          pendAddr[slot]  = addr;
          pendData[slot]  = data;
          pendHit[slot]   = hitTok[0];
          pendName[slot]  = name;
        end
        default: begin
          // idle gap between commands
          repeat ($urandom_range(3, 0)) @(posedge clk);
          if (cmd == "G") begin
            runQueued();
          end else begin
            runCommand(cmd, addr, data, hitTok[0], name);
          end
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    int assertFails;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    timedOut = 1'b0;
    void'($urandom(32'h2a874d86));
    rst_n       = 1'b0;
    iValid      = 1'b0;
    iAddr       = '0;
    dValid      = 1'b0;
    dAddr       = '0;
    hostPsel    = 1'b0;
    hostPenable = 1'b0;
    hostPaddr   = '0;
    hostPwrite  = 1'b0;
    hostPwdata  = '0;
    for (int s = 0; s < 3; s++) begin
      pendValid[s] = 1'b0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    runGolden();
    repeat (4) @(posedge clk);
    assertFails = DUT.u_checker.failCount;
    errors += assertFails;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assertFails);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/cache_pkg.sv
verilog/cache_way_array.sv
verilog/cache.sv
verilog/apb_arbiter.sv
verilog/line_memory.sv
verilog/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cache_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
SIM_ARGS := +verilator+error+limit+1000
PASS_MSG := Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/cache_golden.txt
# columns: command, byte address, data word, expected hit flag (all hex)
# F fills memory, W/R host write/read, I/D cache read, i/d/r/w queue and G runs the queue
F 00000000 0000000000000000 0
# host port write then read back
W 00000400 1122334455667788 0
R 00000400 1122334455667788 0
W 00000408 0BADC0DE0BADC0DE 0
R 00000408 0BADC0DE0BADC0DE 0
# cold misses then hits in the same line
I 00000400 1122334455667788 0
I 00000408 0BADC0DE0BADC0DE 1
I 00000410 00000410FFFFFBEF 1
D 00000120 00000120FFFFFEDF 0
D 00000128 00000128FFFFFED7 1
# three tags in data cache set 2
D 00000040 00000040FFFFFFBF 0
D 00000848 00000848FFFFF7B7 0
D 00000040 00000040FFFFFFBF 1
D 00001050 00001050FFFFEFAF 0
D 00000048 00000048FFFFFFB7 1
D 00000858 00000858FFFFF7A7 0
D 00001058 00001058FFFFEFA7 0
D 00000840 00000840FFFFF7BF 1
# both caches and the host at once
i 00000200 00000200FFFFFDFF 0
d 00000300 00000300FFFFFCFF 0
r 00000500 00000500FFFFFAFF 0
G 00000000 0000000000000000 0
i 00000218 00000218FFFFFDE7 1
d 00000760 00000760FFFFF89F 0
w 00000700 0123456789ABCDEF 0
G 00000000 0000000000000000 0
R 00000700 0123456789ABCDEF 0
D 00000778 00000778FFFFF887 1
# host write to a cached word leaves the old copy in the cache
W 00000408 DEADBEEFCAFEF00D 0
I 00000408 0BADC0DE0BADC0DE 1
R 00000408 DEADBEEFCAFEF00D 0
